// ==== verilog/noc_cfg_pkg.sv ====
package noc_cfg_pkg;

    // router size

    // local port plus four mesh directions
    localparam int num_ports = 5;

    // virtual channels on every input and output port
    localparam int num_vcs = 4;

    // derived widths

    // a packet never turns back to the port it came from
    // so destination one-hots carry only the other ports
    localparam int num_other_ports = num_ports - 1;

endpackage

// ==== verilog/alloc_types_pkg.sv ====
package alloc_types_pkg;

    import noc_cfg_pkg::*;

    // one bit per virtual channel
    typedef logic [num_vcs-1:0] vc_mask_t;

    // one-hot over the other ports in increasing order
    // the owning port's own position is skipped
    typedef logic [num_other_ports-1:0] dest_port_t;

    // everything one input port presents to the allocator
    typedef struct packed {
        vc_mask_t                   ivc_request;
        vc_mask_t                   ovc_is_assigned;
        vc_mask_t                   assigned_ovc_not_full;
        // free output VCs each input VC may still take
        vc_mask_t   [num_vcs-1:0]   masked_ovc_request;
        // routed destination of each input VC
        dest_port_t [num_vcs-1:0]   dest_port;
    } iport_req_t;

    // allocation result returned to one input port
    typedef struct packed {
        vc_mask_t   ivc_sw_grant;
        vc_mask_t   ivc_ovc_grant;
        vc_mask_t   granted_ovc;
        dest_port_t granted_dest_port;
        logic       any_sw_grant;
    } iport_res_t;

    // allocation result seen by one output port
    typedef struct packed {
        vc_mask_t ovc_allocated;
        logic     any_ovc_granted;
    } oport_res_t;

    // first-level winner of an input port
    typedef struct packed {
        vc_mask_t   winner_ivc;
        dest_port_t dest_port;
        vc_mask_t   cand_ovc;
    } cand_t;

endpackage

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int width = noc_cfg_pkg::num_vcs
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] request,
    input  logic             priority_en,
    output logic [width-1:0] grant,
    output logic             any_grant
);

    localparam int ptr_w = (width > 1) ? $clog2(width) : 1;

    // index with highest priority this cycle
    logic [ptr_w-1:0] ptr;
    // encoded index of the current winner
    logic [ptr_w-1:0] win_idx;

    // scan upward from ptr with wrap
    // first requester found wins
    always_comb begin
        int idx;
        grant     = '0;
        any_grant = 1'b0;
        win_idx   = '0;
        for (int i = 0; i < width; i++) begin
            idx = int'(ptr) + i;
            if (idx >= width) begin
                idx = idx - width;
            end
            if (!any_grant && request[idx]) begin
                grant[idx] = 1'b1;
                any_grant  = 1'b1;
                win_idx    = ptr_w'(idx);
            end
        end
    end

    // winner drops to lowest priority once enabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (any_grant && priority_en) begin
            if (win_idx == ptr_w'(width - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= win_idx + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/input_port_stage.sv ====
`timescale 1ns/1ps

module input_port_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  alloc_types_pkg::iport_req_t req,
    input  logic                      any_sw_grant,
    output alloc_types_pkg::cand_t    cand
);

    import noc_cfg_pkg::*;
    import alloc_types_pkg::*;

    // input VCs allowed into first-level arbitration
    vc_mask_t masked_ivc_req;
    // first-level winner, one-hot
    vc_mask_t winner_ivc;
    // candidate free output VC per input VC
    vc_mask_t [num_vcs-1:0] ovc_pick;

    // request masking
    always_comb begin
        for (int v = 0; v < num_vcs; v++) begin
            // owns an output VC with room left
            // or still has a free output VC to ask for
            masked_ivc_req[v] = (req.ivc_request[v] & req.ovc_is_assigned[v]
                                 & req.assigned_ovc_not_full[v])
                                | (|req.masked_ovc_request[v]);
        end
    end

    // input VC arbiter
    // pointer only moves when this port wins the switch
    rr_arbiter #(
        .width(num_vcs)
    ) u_ivc_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .request    (masked_ivc_req),
        .priority_en(any_sw_grant),
        .grant      (winner_ivc),
        .any_grant  ()
    );

    // one output VC arbiter per input VC
    // these run in parallel with the input arbiter
    for (genvar v = 0; v < num_vcs; v++) begin : g_ovc_arb
        rr_arbiter #(
            .width(num_vcs)
        ) u_ovc_arb (
            .clk        (clk),
            .rst_n      (rst_n),
            .request    (req.masked_ovc_request[v]),
            .priority_en(1'b1),
            .grant      (ovc_pick[v]),
            .any_grant  ()
        );
    end

    // one-hot mux of the winner's destination and candidate
    // all zero when no input VC won
    always_comb begin
        cand            = '0;
        cand.winner_ivc = winner_ivc;
        for (int v = 0; v < num_vcs; v++) begin
            if (winner_ivc[v]) begin
                cand.dest_port = cand.dest_port | req.dest_port[v];
                cand.cand_ovc  = cand.cand_ovc | ovc_pick[v];
            end
        end
    end

endmodule

// ==== verilog/switch_output_stage.sv ====
`timescale 1ns/1ps

module switch_output_stage (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  alloc_types_pkg::cand_t     [noc_cfg_pkg::num_ports-1:0] cand,
    output alloc_types_pkg::dest_port_t [noc_cfg_pkg::num_ports-1:0] granted_dest_port,
    output logic                       [noc_cfg_pkg::num_ports-1:0] any_sw_grant,
    output logic                       [noc_cfg_pkg::num_ports-1:0] any_ovc_granted
);

    import noc_cfg_pkg::*;

    // per output port, bit k is the k-th other input port
    logic [num_ports-1:0][num_other_ports-1:0] oarb_req;
    logic [num_ports-1:0][num_other_ports-1:0] oarb_grant;

    for (genvar o = 0; o < num_ports; o++) begin : g_out
        // transpose around the skipped diagonal
        // input i below o sits at slot i and names o at bit o-1
        // input i above o sits at slot i-1 and names o at bit o
        for (genvar i = 0; i < num_ports; i++) begin : g_in
            if (i < o) begin : g_below
                assign oarb_req[o][i]              = cand[i].dest_port[o-1];
                assign granted_dest_port[i][o-1] = oarb_grant[o][i];
            end else if (i > o) begin : g_above
                assign oarb_req[o][i-1]          = cand[i].dest_port[o];
                assign granted_dest_port[i][o] = oarb_grant[o][i-1];
            end
        end

        // output arbiter
        // rotates on every grant
        rr_arbiter #(
            .width(num_other_ports)
        ) u_out_arb (
            .clk        (clk),
            .rst_n      (rst_n),
            .request    (oarb_req[o]),
            .priority_en(1'b1),
            .grant      (oarb_grant[o]),
            .any_grant  (any_ovc_granted[o])
        );
    end

    // an input port won the switch if any output picked it
    for (genvar i = 0; i < num_ports; i++) begin : g_sw_grant
        assign any_sw_grant[i] = |granted_dest_port[i];
    end

endmodule

// ==== verilog/ovc_grant_map.sv ====
`timescale 1ns/1ps

module ovc_grant_map (
    input  alloc_types_pkg::cand_t      [noc_cfg_pkg::num_ports-1:0] cand,
    input  alloc_types_pkg::dest_port_t [noc_cfg_pkg::num_ports-1:0] granted_dest_port,
    input  logic                        [noc_cfg_pkg::num_ports-1:0] any_sw_grant,
    output alloc_types_pkg::vc_mask_t   [noc_cfg_pkg::num_ports-1:0] ivc_sw_grant,
    output alloc_types_pkg::vc_mask_t   [noc_cfg_pkg::num_ports-1:0] ivc_ovc_grant,
    output alloc_types_pkg::vc_mask_t   [noc_cfg_pkg::num_ports-1:0] granted_ovc,
    output alloc_types_pkg::vc_mask_t   [noc_cfg_pkg::num_ports-1:0] ovc_allocated
);

    import noc_cfg_pkg::*;
    import alloc_types_pkg::*;

    // granted candidates spread per output, one slot per other input
    vc_mask_t [num_ports-1:0][num_other_ports-1:0] spread;

    // gating on the input side
    for (genvar i = 0; i < num_ports; i++) begin : g_in_side
        assign ivc_sw_grant[i] = any_sw_grant[i] ? cand[i].winner_ivc : '0;
        assign granted_ovc[i]  = any_sw_grant[i] ? cand[i].cand_ovc : '0;
        // an assigned VC that wins carries no new output VC
        assign ivc_ovc_grant[i] = (any_sw_grant[i] && (|cand[i].cand_ovc))
                                  ? cand[i].winner_ivc : '0;
    end

    // demux each candidate onto the output its grant names
    for (genvar o = 0; o < num_ports; o++) begin : g_out_side
        for (genvar i = 0; i < num_ports; i++) begin : g_in
            if (i < o) begin : g_below
                assign spread[o][i] = granted_dest_port[i][o-1] ? cand[i].cand_ovc : '0;
            end else if (i > o) begin : g_above
                assign spread[o][i-1] = granted_dest_port[i][o] ? cand[i].cand_ovc : '0;
            end
        end
    end

    // at most one slot is live per output
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            ovc_allocated[o] = '0;
            for (int k = 0; k < num_other_ports; k++) begin
                ovc_allocated[o] = ovc_allocated[o] | spread[o][k];
            end
        end
    end

endmodule

// ==== verilog/comb_nonspec_alloc.sv ====
`timescale 1ns/1ps

module comb_nonspec_alloc (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  alloc_types_pkg::iport_req_t [noc_cfg_pkg::num_ports-1:0] iport_req,
    output alloc_types_pkg::iport_res_t [noc_cfg_pkg::num_ports-1:0] iport_res,
    output alloc_types_pkg::oport_res_t [noc_cfg_pkg::num_ports-1:0] oport_res
);

    import noc_cfg_pkg::*;
    import alloc_types_pkg::*;

    // first-level winners of all input ports
    cand_t      [num_ports-1:0] cand;
    dest_port_t [num_ports-1:0] granted_dest_port;
    logic       [num_ports-1:0] any_sw_grant;
    logic       [num_ports-1:0] any_ovc_granted;
    vc_mask_t   [num_ports-1:0] ivc_sw_grant;
    vc_mask_t   [num_ports-1:0] ivc_ovc_grant;
    vc_mask_t   [num_ports-1:0] granted_ovc;
    vc_mask_t   [num_ports-1:0] ovc_allocated;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        input_port_stage u_in_stage (
            .clk         (clk),
            .rst_n       (rst_n),
            .req         (iport_req[p]),
            .any_sw_grant(any_sw_grant[p]),
            .cand        (cand[p])
        );

        // pack per-port results
        assign iport_res[p].ivc_sw_grant      = ivc_sw_grant[p];
        assign iport_res[p].ivc_ovc_grant     = ivc_ovc_grant[p];
        assign iport_res[p].granted_ovc       = granted_ovc[p];
        assign iport_res[p].granted_dest_port = granted_dest_port[p];
        assign iport_res[p].any_sw_grant      = any_sw_grant[p];
        assign oport_res[p].ovc_allocated     = ovc_allocated[p];
        assign oport_res[p].any_ovc_granted   = any_ovc_granted[p];
    end

    // second-level switch arbitration
    switch_output_stage u_sw_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .cand             (cand),
        .granted_dest_port(granted_dest_port),
        .any_sw_grant     (any_sw_grant),
        .any_ovc_granted  (any_ovc_granted)
    );

    // output VC results from the switch outcome
    ovc_grant_map u_grant_map (
        .cand             (cand),
        .granted_dest_port(granted_dest_port),
        .any_sw_grant     (any_sw_grant),
        .ivc_sw_grant     (ivc_sw_grant),
        .ivc_ovc_grant    (ivc_ovc_grant),
        .granted_ovc      (granted_ovc),
        .ovc_allocated    (ovc_allocated)
    );

endmodule

// ==== dv/tb_comb_nonspec_alloc.sv ====
`timescale 1ns/1ps

module tb_comb_nonspec_alloc;

    import noc_cfg_pkg::*;
    import alloc_types_pkg::*;

    // one line of the tests file
    typedef struct packed {
        iport_req_t [num_ports-1:0]       req;
        // S O G D hex digits per input
        logic       [num_ports-1:0][15:0] exp_in;
        // ovc_allocated and any_ovc_granted digits per output
        logic       [num_ports-1:0][7:0]  exp_out;
    } test_vec_t;

    logic                       clk;
    logic                       rst_n;
    iport_req_t [num_ports-1:0] iport_req;
    iport_res_t [num_ports-1:0] iport_res;
    oport_res_t [num_ports-1:0] oport_res;

    test_vec_t vecs[$];
    int        errors;
    int        cycles;
    // zero until the vectors are loaded
    int        cycle_limit;
    int        vec_done;

    comb_nonspec_alloc i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .iport_req(iport_req),
        .iport_res(iport_res),
        .oport_res(oport_res)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reads every vector before the clock starts counting
    task automatic load_vectors(output bit ok);
        int                          fd;
        int                          n;
        int                          line_no;
        string                       line;
        logic [$bits(iport_req_t)-1:0] rq [num_ports];
        logic [15:0]                 ei [num_ports];
        logic [7:0]                  eo [num_ports];
        test_vec_t                   tv;
        ok      = 1'b1;
        line_no = 0;
        fd      = $fopen("dv/alloc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/alloc_tests.txt for reading");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                // skip blank and comment lines
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                rq[0], rq[1], rq[2], rq[3], rq[4],
                                ei[0], ei[1], ei[2], ei[3], ei[4],
                                eo[0], eo[1], eo[2], eo[3], eo[4]);
                    if (n > 0 && n != 15) begin
                        $display("line %0d of the tests file has %0d of 15 fields", line_no, n);
                        ok = 1'b0;
                    end else if (n == 15) begin
                        for (int p = 0; p < num_ports; p++) begin
                            tv.req[p]     = rq[p];
                            tv.exp_in[p]  = ei[p];
                            tv.exp_out[p] = eo[p];
                        end
                        vecs.push_back(tv);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input int idx, input int port, input string field,
                                   input logic [3:0] got, input logic [3:0] expv);
        errors++;
        $display("CHECK FAILED at %0t: vector %0d port %0d %s got %h expected %h",
                 $time, idx, port, field, got, expv);
    endtask

    // compares all results against one vector
    task automatic check_vector(input int idx, input test_vec_t tv);
        vc_mask_t   exp_s;
        vc_mask_t   exp_o;
        vc_mask_t   exp_g;
        dest_port_t exp_d;
        vc_mask_t   exp_alloc;
        logic       exp_any;
        for (int p = 0; p < num_ports; p++) begin
            exp_s     = tv.exp_in[p][15:12];
            exp_o     = tv.exp_in[p][11:8];
            exp_g     = tv.exp_in[p][7:4];
            exp_d     = tv.exp_in[p][3:0];
            exp_alloc = tv.exp_out[p][7:4];
            exp_any   = tv.exp_out[p][0];
            if (iport_res[p].ivc_sw_grant !== exp_s) begin
                report_mismatch(idx, p, "ivc_sw_grant", iport_res[p].ivc_sw_grant, exp_s);
            end
            if (iport_res[p].ivc_ovc_grant !== exp_o) begin
                report_mismatch(idx, p, "ivc_ovc_grant", iport_res[p].ivc_ovc_grant, exp_o);
            end
            if (iport_res[p].granted_ovc !== exp_g) begin
                report_mismatch(idx, p, "granted_ovc", iport_res[p].granted_ovc, exp_g);
            end
            if (iport_res[p].granted_dest_port !== exp_d) begin
                report_mismatch(idx, p, "granted_dest_port",
                                iport_res[p].granted_dest_port, exp_d);
            end
            // switch win is the OR of the granted destinations
            if (iport_res[p].any_sw_grant !== (|exp_d)) begin
                report_mismatch(idx, p, "any_sw_grant",
                                {3'b000, iport_res[p].any_sw_grant}, {3'b000, |exp_d});
            end
            if (oport_res[p].ovc_allocated !== exp_alloc) begin
                report_mismatch(idx, p, "ovc_allocated", oport_res[p].ovc_allocated, exp_alloc);
            end
            if (oport_res[p].any_ovc_granted !== exp_any) begin
                report_mismatch(idx, p, "any_ovc_granted",
                                {3'b000, oport_res[p].any_ovc_granted}, {3'b000, exp_any});
            end
        end
    endtask

    task automatic finish_run();
        $display("vectors run: %0d, errors: %0d", vec_done, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // run limit scales with the vector count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d vectors checked", cycles, vec_done);
            errors++;
            finish_run();
        end
    end

    initial begin
        bit load_ok;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        vec_done    = 0;
        rst_n       = 1'b0;
        iport_req   = '0;
        load_vectors(load_ok);
        if (!load_ok || vecs.size() == 0) begin
            $display("no usable test vectors were loaded, nothing was run");
            errors++;
        end else begin
            cycle_limit = 10 + vecs.size() + 20;
            // reset held through the first 10 rising edges
            repeat (10) @(posedge clk);
            for (int k = 0; k < vecs.size(); k++) begin
                // drive after the edge, check just before the next one
                #1;
                rst_n     = 1'b1;
                iport_req = vecs[k].req;
                #2;
                check_vector(k, vecs[k]);
                vec_done++;
                @(posedge clk);
            end
        end
        finish_run();
    end

endmodule

// ==== dv/alloc_tests.txt ====
# columns 1-5 are iport_req per input as hex digits R A N M3 M2 M1 M0 D3 D2 D1 D0
# columns 6-10 are expected S O G D per input and 11-15 expected ovc_allocated and any per output
#
# idle then a single assigned VC from input 0 toward output 1
00000000000 00000000000 00000000000 00000000000 00000000000 0000 0000 0000 0000 0000 00 00 00 00 00
44400000100 00000000000 00000000000 00000000000 00000000000 4001 0000 0000 0000 0000 00 01 00 00 00
#
# input 4 rotates over all four VCs toward output 2
00000000000 00000000000 00000000000 00000000000 FFF00004444 0000 0000 0000 0000 1004 00 00 01 00 00
00000000000 00000000000 00000000000 00000000000 FFF00004444 0000 0000 0000 0000 2004 00 00 01 00 00
00000000000 00000000000 00000000000 00000000000 FFF00004444 0000 0000 0000 0000 4004 00 00 01 00 00
00000000000 00000000000 00000000000 00000000000 FFF00004444 0000 0000 0000 0000 8004 00 00 01 00 00
00000000000 00000000000 00000000000 00000000000 FFF00004444 0000 0000 0000 0000 1004 00 00 01 00 00
#
# inputs 1 2 3 contend for output 0 and input 2 keeps its VC while losing
00000000000 11100000001 33300000011 11100000001 00000000000 0000 1001 0000 0000 0000 01 00 00 00 00
00000000000 11100000001 33300000011 11100000001 00000000000 0000 0000 1001 0000 0000 01 00 00 00 00
00000000000 11100000001 33300000011 11100000001 00000000000 0000 0000 0000 1001 0000 01 00 00 00 00
00000000000 11100000001 33300000011 11100000001 00000000000 0000 1001 0000 0000 0000 01 00 00 00 00
00000000000 11100000001 33300000011 11100000001 00000000000 0000 0000 2001 0000 0000 01 00 00 00 00
00000000000 11100000001 33300000011 11100000001 00000000000 0000 0000 0000 1001 0000 01 00 00 00 00
#
# free VC candidates rotate for input 0 VC 1 toward output 3
20000B00040 00000000000 00000000000 00000000000 00000000000 2214 0000 0000 0000 0000 00 00 00 11 00
20000B00040 00000000000 00000000000 00000000000 00000000000 2224 0000 0000 0000 0000 00 00 00 21 00
20000B00040 00000000000 00000000000 00000000000 00000000000 2284 0000 0000 0000 0000 00 00 00 81 00
20000B00040 00000000000 00000000000 00000000000 00000000000 2214 0000 0000 0000 0000 00 00 00 11 00
#
# inputs 0 and 4 both want a free VC at output 3
20000B00040 00000000000 00000000000 00000000000 4000C000800 0000 0000 0000 0000 4448 00 00 00 41 00
20000B00040 00000000000 00000000000 00000000000 4000C000800 2284 0000 0000 0000 0000 00 00 00 81 00
#
# input 3 VC 3 owns a full output VC and is masked out
00000000000 00000000000 00000000000 88000002000 00000000000 0000 0000 0000 0000 0000 00 00 00 00 00
00000000000 00000000000 00000000000 99100002002 00000000000 0000 0000 0000 1002 0000 00 01 00 00 00
00000000000 00000000000 00000000000 99100002002 00000000000 0000 0000 0000 1002 0000 00 01 00 00 00
#
# several outputs in one cycle
11100000008 40003000800 88800001000 00000000000 20000800020 1008 0000 8001 0000 2282 01 81 00 00 01
11100000008 40003000800 88800001000 00000000000 20000800020 0000 4428 8001 0000 2282 01 81 00 00 21
00000000000 00000000000 00000000000 00000000000 00000000000 0000 0000 0000 0000 0000 00 00 00 00 00

// ==== files.f ====
verilog/noc_cfg_pkg.sv
verilog/alloc_types_pkg.sv
verilog/rr_arbiter.sv
verilog/input_port_stage.sv
verilog/switch_output_stage.sv
verilog/ovc_grant_map.sv
verilog/comb_nonspec_alloc.sv
dv/tb_comb_nonspec_alloc.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary -f files.f --top-module tb_comb_nonspec_alloc -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
